// ==== rv64_core.f ====
design/rv64_pkg.sv
design/rv64_bus_if.sv
design/rv64_dec_if.sv
design/rv64_decode.sv
design/rv64_regfile.sv
design/rv64_csr.sv
design/rv64_exec.sv
design/rv64_core.sv
verification/rv64_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module rv64_core_tb -f rv64_core.f -o rv64_sim
./obj_dir/rv64_sim > sim.log 2>&1 || true
cat sim.log

if ! grep -q "Simulation completed successfully" sim.log; then
    exit 1
fi

// ==== verification/rv64_core_tb.sv ====
`timescale 1ns/1ps

module rv64_core_tb;

    localparam logic [63:0] RESET_PC    = 64'h0000_0000_8000_0000;
    localparam logic [63:0] MTVEC_RESET = 64'h0000_0000_8000_0400;
    localparam int          PROG_LEN    = 27;                     // Main program plus handler
    localparam int          CYCLE_LIMIT = 40 * PROG_LEN + 200;
    localparam logic [31:0] NOP         = 32'h0000_0013;          // addi x0, x0, 0

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [63:0] pc;
    logic        heartbeat;
    logic [3:0]  interrupt_vector;
    logic        interrupt_ack;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    logic [63:0] bus_read_data;

    logic [31:0] imem [0:511];
    logic [63:0] dmem [logic [63:0]];
    logic [63:0] exp_addr [$];   // Expected store addresses
    logic [63:0] exp_data [$];
    logic [63:0] exp_ld [$];     // Expected load addresses
    logic [31:0] lfsr_state = 32'hd3b7_55e8;
    int          errors = 0;
    int          cycles = 0;
    int          ack_count = 0;
    int          irq_state = 0;
    logic        hb_prev = 1'b0;
    logic        hb_valid = 1'b0;   // Previous sample taken out of reset

    rv64_core #(.RESET_PC(RESET_PC), .MTVEC_RESET(MTVEC_RESET)) i_rv64_core (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], b};
            r = {r[30:0], b};
        end
        return r;
    endfunction

    // Unwritten data words, derived from the full address
    function automatic logic [63:0] mem_fill(input logic [63:0] a);
        return {a[31:0] ^ a[63:32], ~a[31:0]};
    endfunction

    function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sd_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 512; i++) begin
            imem[i] = NOP;
        end
        imem[0]  = {20'h10000, 5'd1, 7'b0110111};             // x1 = data base
        imem[1]  = {20'(rand_bits(20)), 5'd2, 7'b0110111};
        imem[2]  = itype_word(7'b0010011, 3'b000, 5'd2, 5'd2, 12'(rand_bits(12)));
        imem[3]  = sd_word(5'd2, 5'd1, 12'd0);
        imem[4]  = itype_word(7'b0010011, 3'b000, 5'd0, 5'd2, 12'(rand_bits(12)));   // Into x0
        imem[5]  = sd_word(5'd0, 5'd1, 12'd8);
        imem[6]  = itype_word(7'b0010011, 3'b000, 5'd3, 5'd0, 12'(rand_bits(12)));
        imem[7]  = sd_word(5'd3, 5'd1, 12'd16);
        imem[8]  = itype_word(7'b0000011, 3'b011, 5'd4, 5'd1, 12'd16);   // LD round trip
        imem[9]  = sd_word(5'd4, 5'd1, 12'd24);
        imem[10] = jal_word(5'd5, 21'd12);
        imem[11] = sd_word(5'd2, 5'd1, 12'd32);   // Skipped
        imem[12] = sd_word(5'd2, 5'd1, 12'd40);   // Skipped
        imem[13] = sd_word(5'd5, 5'd1, 12'd48);
        imem[15] = itype_word(7'b1100111, 3'b000, 5'd7, 5'd5, 12'd29);   // Odd sum, bit 0 dropped
        imem[16] = sd_word(5'd2, 5'd1, 12'd56);
        imem[17] = sd_word(5'd2, 5'd1, 12'd64);
        imem[18] = sd_word(5'd7, 5'd1, 12'd72);
        imem[19] = itype_word(7'b0010011, 3'b000, 5'd8, 5'd0, 12'd7);    // Interrupted here
        imem[20] = itype_word(7'b0010011, 3'b000, 5'd8, 5'd8, 12'd1);
        imem[21] = sd_word(5'd8, 5'd1, 12'd80);
        imem[22] = jal_word(5'd0, 21'd0);                                 // Park
        imem[256] = itype_word(7'b0010011, 3'b000, 5'd9, 5'd0, 12'h055);  // Handler
        imem[257] = sd_word(5'd9, 5'd1, 12'd88);
        imem[259] = 32'h3020_0073;                                        // MRET
    endtask

    // Architectural model, interrupt taken once before word 19
    function automatic void rv64_iss();
        logic [63:0] x [32];
        logic [63:0] ref_mem [logic [63:0]];
        logic [63:0] iss_pc;
        logic [63:0] nxt;
        logic [63:0] ea;
        logic [63:0] mepc_r;
        logic [31:0] ir;
        logic        irq_done;
        logic        parked;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        iss_pc   = RESET_PC;
        mepc_r   = '0;
        irq_done = 1'b0;
        parked   = 1'b0;
        for (int s = 0; s < 300 && !parked; s++) begin
            if (!irq_done && iss_pc == RESET_PC + 64'd76) begin
                mepc_r   = iss_pc;
                iss_pc   = MTVEC_RESET;
                irq_done = 1'b1;
            end
            ir  = imem[9'((iss_pc - RESET_PC) >> 2)];
            nxt = iss_pc + 64'd4;
            ea  = x[ir[19:15]] + {{52{ir[31]}}, ir[31:20]};
            case (ir[6:0])
                7'b0110111: x[ir[11:7]] = {{32{ir[31]}}, ir[31:12], 12'b0};
                7'b0010011: x[ir[11:7]] = ea;
                7'b0000011: begin
                    exp_ld.push_back(ea);
                    x[ir[11:7]] = ref_mem.exists(ea) ? ref_mem[ea] : mem_fill(ea);
                end
                7'b0100011: begin
                    ea = x[ir[19:15]] + {{52{ir[31]}}, ir[31:25], ir[11:7]};
                    exp_addr.push_back(ea);
                    exp_data.push_back(x[ir[24:20]]);
                    ref_mem[ea] = x[ir[24:20]];
                end
                7'b1101111: begin
                    nxt = iss_pc + {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
                    parked = (nxt == iss_pc);
                    x[ir[11:7]] = iss_pc + 64'd4;
                end
                7'b1100111: begin
                    nxt = {ea[63:1], 1'b0};
                    x[ir[11:7]] = iss_pc + 64'd4;
                end
                7'b1110011: nxt = mepc_r;
                default: ;
            endcase
            x[0]   = '0;
            iss_pc = nxt;
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Fetch and interrupt stimulus
    always @(negedge clk) begin
        instruction <= imem[9'((pc - RESET_PC) >> 2)];
        case (irq_state)
            0: begin
                if (pc == RESET_PC + 64'd80) begin   // Word 19 in execute
                    interrupt_vector <= 4'd1;
                    irq_state        <= 1;
                end
            end
            1: begin
                if (interrupt_ack) begin
                    interrupt_vector <= 4'd0;
                    irq_state        <= 2;
                end
            end
            2: begin
                if (pc == MTVEC_RESET + 64'd8) begin   // Second request inside handler
                    interrupt_vector <= 4'd1;
                    irq_state        <= 3;
                end
            end
            3: begin
                if (pc == MTVEC_RESET + 64'd16) begin
                    interrupt_vector <= 4'd0;
                    irq_state        <= 4;
                end
            end
            default: ;
        endcase
    end

    // Data memory and bus compare
    always @(negedge clk) begin
        if (reset && bus_write_enable) begin
            dmem[bus_address] = bus_write_data;
            if (exp_addr.size() == 0) begin
                $display("Unexpected bus write at address %h", bus_address);
                errors++;
            end else begin
                check_value("bus_address", bus_address, exp_addr.pop_front());
                check_value("bus_write_data", bus_write_data, exp_data.pop_front());
            end
        end
        if (reset && bus_read_enable) begin
            bus_read_data <= dmem.exists(bus_address) ? dmem[bus_address] : mem_fill(bus_address);
            if (exp_ld.size() == 0) begin
                $display("Unexpected bus read at address %h", bus_address);
                errors++;
            end else begin
                check_value("bus_address", bus_address, exp_ld.pop_front());
            end
        end
        if (reset && interrupt_ack) begin
            ack_count++;
            check_value("pc", pc, MTVEC_RESET);   // Trap vector loaded with the ack
        end
    end

    // Heartbeat flips on every clock out of reset
    always @(negedge clk) begin
        if (reset && hb_valid) begin
            check_value("heartbeat", 64'(heartbeat), 64'(!hb_prev));
        end
        hb_prev  = heartbeat;
        hb_valid = reset;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, errors %0d", cycles, errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset            = 1'b0;
        instruction      = NOP;
        interrupt_vector = 4'd0;
        bus_read_data    = '0;
        load_program();
        rv64_iss();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("pc", pc, RESET_PC);
        check_value("bus_write_enable", 64'(bus_write_enable), 64'd0);
        check_value("bus_read_enable", 64'(bus_read_enable), 64'd0);
        check_value("interrupt_ack", 64'(interrupt_ack), 64'd0);
        check_value("heartbeat", 64'(heartbeat), 64'd0);
        reset = 1'b1;
        @(negedge clk);
        check_value("pc", pc, RESET_PC + 64'd4);   // Fetch moved on
        while (exp_addr.size() != 0 || exp_ld.size() != 0) begin
            @(negedge clk);
        end
        repeat (30) @(negedge clk);   // Catch stray writes
        check_value("ack_count", 64'(ack_count), 64'd1);
        $display("Errors: %0d, cycles: %0d, acks: %0d", errors, cycles, ack_count);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== design/rv64_core.sv ====
`timescale 1ns/1ps

module rv64_core #(
    parameter logic [63:0] RESET_PC    = 64'h0000_0000_8000_0000,
    parameter logic [63:0] MTVEC_RESET = 64'h0000_0000_8000_0400
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [rv64_pkg::ILEN-1:0] instruction,
    output logic [rv64_pkg::XLEN-1:0] pc,
    output logic                      heartbeat,
    input  logic [3:0]                interrupt_vector,
    output logic                      interrupt_ack,
    output logic [rv64_pkg::XLEN-1:0] bus_address,
    output logic [rv64_pkg::XLEN-1:0] bus_write_data,
    output logic                      bus_write_enable,
    output logic                      bus_read_enable,
    input  logic [rv64_pkg::XLEN-1:0] bus_read_data
);

    logic [rv64_pkg::XLEN-1:0] rs1_data;
    logic [rv64_pkg::XLEN-1:0] rs2_data;
    logic                      wr_en;
    logic [4:0]                wr_addr;
    logic [rv64_pkg::XLEN-1:0] wr_data;
    logic                      trap_take;
    logic                      mret_take;
    logic [rv64_pkg::XLEN-1:0] trap_pc;
    logic                      mie;
    logic [rv64_pkg::XLEN-1:0] mepc;
    logic [rv64_pkg::XLEN-1:0] mtvec;

    rv64_bus_if bus_if ();
    rv64_dec_if dec_if ();

    // Bus pins
    assign bus_address      = bus_if.address;
    assign bus_write_data   = bus_if.write_data;
    assign bus_write_enable = bus_if.write_enable;
    assign bus_read_enable  = bus_if.read_enable;
    assign bus_if.read_data = bus_read_data;

    // Alive indicator, flips every clock
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            heartbeat <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat;
        end
    end

    rv64_decode i_rv64_decode (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .dec         (dec_if.source)
    );

    rv64_regfile i_rv64_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (dec_if.rs1),
        .rs2_addr (dec_if.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    rv64_csr #(
        .MTVEC_RESET (MTVEC_RESET)
    ) i_rv64_csr (
        .clk       (clk),
        .reset     (reset),
        .trap_take (trap_take),
        .mret_take (mret_take),
        .trap_pc   (trap_pc),
        .mie       (mie),
        .mepc      (mepc),
        .mtvec     (mtvec)
    );

    rv64_exec #(
        .RESET_PC (RESET_PC)
    ) i_rv64_exec (
        .clk              (clk),
        .reset            (reset),
        .dec              (dec_if.sink),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .trap_take        (trap_take),
        .mret_take        (mret_take),
        .trap_pc          (trap_pc),
        .mie              (mie),
        .mepc             (mepc),
        .mtvec            (mtvec),
        .bus              (bus_if.master),
        .pc               (pc)
    );

endmodule

// ==== design/rv64_exec.sv ====
`timescale 1ns/1ps

module rv64_exec #(
    parameter logic [63:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    rv64_dec_if.sink                  dec,
    input  logic [rv64_pkg::XLEN-1:0] rs1_data,
    input  logic [rv64_pkg::XLEN-1:0] rs2_data,
    output logic                      wr_en,
    output logic [4:0]                wr_addr,
    output logic [rv64_pkg::XLEN-1:0] wr_data,
    input  logic [3:0]                interrupt_vector,
    output logic                      interrupt_ack,
    output logic                      trap_take,
    output logic                      mret_take,
    output logic [rv64_pkg::XLEN-1:0] trap_pc,
    input  logic                      mie,
    input  logic [rv64_pkg::XLEN-1:0] mepc,
    input  logic [rv64_pkg::XLEN-1:0] mtvec,
    rv64_bus_if.master                bus,
    output logic [rv64_pkg::XLEN-1:0] pc
);

    // Two-step load sequence
    typedef enum logic {
        LD_ADDR,   // Issue read
        LD_DATA    // Capture read_data
    } ld_step_e;

    logic                      bubble;      // Flush the IR this cycle
    ld_step_e                  ld_step;
    logic                      exec_en;
    logic [rv64_pkg::XLEN-1:0] mem_addr;
    logic [rv64_pkg::XLEN-1:0] jalr_sum;

    // pc already points one word past the IR during execute
    assign trap_take = !bubble && interrupt_vector == 4'd1 && mie;
    assign trap_pc   = pc - 64'd4;               // Replaced instruction, rerun on MRET
    assign exec_en   = !bubble && !trap_take;
    assign mem_addr  = rs1_data + dec.imm;
    assign jalr_sum  = rs1_data + dec.imm;
    assign mret_take = exec_en && dec.op == rv64_pkg::OP_MRET;
    assign wr_addr   = dec.rd;

    // Write-back select, regfile drops x0
    always_comb begin
        wr_en   = 1'b0;
        wr_data = '0;
        if (exec_en) begin
            case (dec.op)
                rv64_pkg::OP_LUI: begin
                    wr_en   = 1'b1;
                    wr_data = dec.imm;
                end
                rv64_pkg::OP_ADDI: begin
                    wr_en   = 1'b1;
                    wr_data = rs1_data + dec.imm;
                end
                rv64_pkg::OP_LD: begin
                    wr_en   = (ld_step == LD_DATA);   // Second pass only
                    wr_data = bus.read_data;
                end
                rv64_pkg::OP_JAL, rv64_pkg::OP_JALR: begin
                    wr_en   = 1'b1;
                    wr_data = pc;   // Link = jump address + 4
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc               <= RESET_PC;
            bubble           <= 1'b0;
            ld_step          <= LD_ADDR;
            interrupt_ack    <= 1'b0;
            bus.address      <= RESET_PC;
            bus.write_data   <= '0;
            bus.write_enable <= 1'b0;
            bus.read_enable  <= 1'b0;
        end else begin
            pc               <= pc + 64'd4;   // Default, overridden below
            interrupt_ack    <= 1'b0;
            bus.write_enable <= 1'b0;
            bus.read_enable  <= 1'b0;
            if (bubble) begin
                bubble <= 1'b0;   // Discard wrongly fetched word
            end else if (trap_take) begin
                pc            <= mtvec;
                bubble        <= 1'b1;
                interrupt_ack <= 1'b1;
                ld_step       <= LD_ADDR;   // Interrupted load restarts
            end else begin
                case (dec.op)
                    rv64_pkg::OP_LD: begin
                        if (ld_step == LD_ADDR) begin
                            bus.address     <= mem_addr;
                            bus.read_enable <= 1'b1;
                            pc              <= pc - 64'd4;   // Refetch the LD itself
                            bubble          <= 1'b1;
                            ld_step         <= LD_DATA;
                        end else begin
                            ld_step <= LD_ADDR;
                        end
                    end
                    rv64_pkg::OP_SD: begin
                        bus.address      <= mem_addr;
                        bus.write_data   <= rs2_data;
                        bus.write_enable <= 1'b1;
                        pc               <= pc;   // Next word refetched after bubble
                        bubble           <= 1'b1;
                    end
                    rv64_pkg::OP_JAL: begin
                        pc     <= pc - 64'd4 + dec.imm;
                        bubble <= 1'b1;
                    end
                    rv64_pkg::OP_JALR: begin
                        pc     <= {jalr_sum[rv64_pkg::XLEN-1:1], 1'b0};
                        bubble <= 1'b1;
                    end
                    rv64_pkg::OP_MRET: begin
                        pc     <= mepc;
                        bubble <= 1'b1;
                    end
                    default: ;   // LUI, ADDI, NOP just advance
                endcase
            end
        end
    end

endmodule

// ==== design/rv64_csr.sv ====
`timescale 1ns/1ps

module rv64_csr #(
    parameter logic [63:0] MTVEC_RESET = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      trap_take,   // Pulse on interrupt entry
    input  logic                      mret_take,   // Pulse on MRET
    input  logic [rv64_pkg::XLEN-1:0] trap_pc,
    output logic                      mie,
    output logic [rv64_pkg::XLEN-1:0] mepc,
    output logic [rv64_pkg::XLEN-1:0] mtvec
);

    logic [rv64_pkg::XLEN-1:0] mstatus;
    logic [rv64_pkg::XLEN-1:0] mepc_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus                        <= '0;
            mstatus[rv64_pkg::MSTATUS_MIE] <= 1'b1;   // Interrupts open out of reset
            mepc_q                         <= '0;
        end else if (trap_take) begin
            mepc_q                          <= trap_pc;
            mstatus[rv64_pkg::MSTATUS_MPIE] <= mstatus[rv64_pkg::MSTATUS_MIE];
            mstatus[rv64_pkg::MSTATUS_MIE]  <= 1'b0;   // Handler runs masked
        end else if (mret_take) begin
            // Restore enable, MPIE set per spec
            mstatus[rv64_pkg::MSTATUS_MIE]  <= mstatus[rv64_pkg::MSTATUS_MPIE];
            mstatus[rv64_pkg::MSTATUS_MPIE] <= 1'b1;
        end
    end

    assign mie   = mstatus[rv64_pkg::MSTATUS_MIE];
    assign mepc  = mepc_q;
    assign mtvec = MTVEC_RESET;   // Direct mode, fixed base

endmodule

// ==== design/rv64_regfile.sv ====
`timescale 1ns/1ps

module rv64_regfile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [4:0]                rs1_addr,
    input  logic [4:0]                rs2_addr,
    output logic [rv64_pkg::XLEN-1:0] rs1_data,
    output logic [rv64_pkg::XLEN-1:0] rs2_data,
    input  logic                      wr_en,
    input  logic [4:0]                wr_addr,
    input  logic [rv64_pkg::XLEN-1:0] wr_data
);

    logic [rv64_pkg::XLEN-1:0] regs [0:31];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin   // x0 never written
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== design/rv64_decode.sv ====
`timescale 1ns/1ps

module rv64_decode (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [rv64_pkg::ILEN-1:0] instruction,
    rv64_dec_if.source                dec
);

    localparam logic [11:0] MRET_FUNCT12 = 12'h302;

    logic [rv64_pkg::ILEN-1:0] ir;
    rv64_pkg::rv64_opcode_e    opcode;
    logic [2:0]                funct3;
    logic [rv64_pkg::XLEN-1:0] imm_u;
    logic [rv64_pkg::XLEN-1:0] imm_i;
    logic [rv64_pkg::XLEN-1:0] imm_s;
    logic [rv64_pkg::XLEN-1:0] imm_j;

    // Fetch register, loaded every edge, bubbles are handled downstream
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= rv64_pkg::NOP_WORD;
        end else begin
            ir <= instruction;
        end
    end

    assign opcode = rv64_pkg::rv64_opcode_e'(ir[6:0]);
    assign funct3 = ir[14:12];

    // Immediate formats
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_j = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};   // Bit 0 always zero

    assign dec.rd  = ir[11:7];
    assign dec.rs1 = ir[19:15];
    assign dec.rs2 = ir[24:20];

    always_comb begin
        dec.op  = rv64_pkg::OP_NOP;   // Unknown encodings fall through as no-op
        dec.imm = '0;
        case (opcode)
            rv64_pkg::OPC_LUI: begin
                dec.op  = rv64_pkg::OP_LUI;
                dec.imm = imm_u;
            end
            rv64_pkg::OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin   // ADDI only
                    dec.op  = rv64_pkg::OP_ADDI;
                    dec.imm = imm_i;
                end
            end
            rv64_pkg::OPC_LOAD: begin
                if (funct3 == 3'b011) begin   // Doubleword
                    dec.op  = rv64_pkg::OP_LD;
                    dec.imm = imm_i;
                end
            end
            rv64_pkg::OPC_STORE: begin
                if (funct3 == 3'b011) begin
                    dec.op  = rv64_pkg::OP_SD;
                    dec.imm = imm_s;
                end
            end
            rv64_pkg::OPC_JAL: begin
                dec.op  = rv64_pkg::OP_JAL;
                dec.imm = imm_j;
            end
            rv64_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    dec.op  = rv64_pkg::OP_JALR;
                    dec.imm = imm_i;
                end
            end
            rv64_pkg::OPC_SYSTEM: begin
                if (funct3 == 3'b000 && ir[31:20] == MRET_FUNCT12) begin
                    dec.op = rv64_pkg::OP_MRET;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== design/rv64_dec_if.sv ====
`timescale 1ns/1ps

// Decoded fields of the instruction register
interface rv64_dec_if;

    rv64_pkg::rv64_op_e        op;
    logic [4:0]                rd;
    logic [4:0]                rs1;
    logic [4:0]                rs2;
    logic [rv64_pkg::XLEN-1:0] imm;   // Already sign extended per format

    modport source (output op, rd, rs1, rs2, imm);

    modport sink (input op, rd, rs1, rs2, imm);

endinterface

// ==== design/rv64_bus_if.sv ====
`timescale 1ns/1ps

// Data bus, single-cycle enables, no wait states
interface rv64_bus_if;

    logic [rv64_pkg::XLEN-1:0] address;
    logic [rv64_pkg::XLEN-1:0] write_data;
    logic                      write_enable;   // One cycle per store
    logic                      read_enable;    // Data expected one cycle later
    logic [rv64_pkg::XLEN-1:0] read_data;

    // Execute stage side
    modport master (output address, write_data, write_enable, read_enable, input read_data);

    // Core top side, maps onto plain pins
    modport top (input address, write_data, write_enable, read_enable, output read_data);

endinterface

// ==== design/rv64_pkg.sv ====
package rv64_pkg;

    localparam int XLEN = 64;   // Integer register and address width
    localparam int ILEN = 32;   // Fetched instruction width

    // Operation classes leaving the decoder
    typedef enum logic [2:0] {
        OP_NOP,     // Anything unsupported lands here
        OP_LUI,
        OP_ADDI,
        OP_LD,
        OP_SD,
        OP_JAL,
        OP_JALR,
        OP_MRET
    } rv64_op_e;

    // Major opcode field ir[6:0], only the groups this core looks at
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_LUI    = 7'b0110111,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } rv64_opcode_e;

    // Interrupt flag in the MSB, cause code 11
    localparam logic [XLEN-1:0] CAUSE_MEXT = 64'h8000_0000_0000_000B;

    // IR contents out of reset, opcode bits match no group
    localparam logic [ILEN-1:0] NOP_WORD = 32'h0000_0001;

    // mstatus bit positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

endpackage
